// ==== vlog.f ====
+incdir+include
rtl/rs_alu_pkg.sv
rtl/rs_wakeup.sv
rtl/rs_entry_array.sv
rtl/rs_age_matrix.sv
rtl/rs_issue_stage.sv
rtl/rs_alu_top.sv
tb/tb_rs_alu.sv

// ==== Bender.yml ====
package:
  name: rs_alu

export_include_dirs:
  - include

sources:
  - rtl/rs_alu_pkg.sv
  - rtl/rs_wakeup.sv
  - rtl/rs_entry_array.sv
  - rtl/rs_age_matrix.sv
  - rtl/rs_issue_stage.sv
  - rtl/rs_alu_top.sv
  - target: test
    files:
      - tb/tb_rs_alu.sv

// ==== tb/tb_rs_alu.sv ====
`timescale 1ns/1ps
`include "rs_alu_macros.svh"

module tb_rs_alu
    import rs_alu_pkg::*;
;

    // one scenario: up to four dispatches, four broadcasts and the expected issue order
    typedef struct packed {
        logic [3:0]       scen;
        logic [2:0]       n_uops;
        uop_t [3:0]       uops;
        logic [3:0][7:0]  disp_cyc;
        logic [2:0]       n_wb;
        logic [3:0][2:0]  wb_idx;
        phys_tag_t [3:0]  wb_tag;
        logic [3:0][7:0]  wb_cyc;
        logic             withhold;     // alu keeps its credits until credit_cyc
        logic [7:0]       credit_cyc;
        logic [7:0]       flush_cyc;    // 0 when the row has no flush
        logic [7:0]       first_cyc;    // exact cycle of the first issue, 0 = unchecked
        logic [2:0]       n_exp;
        word_t [3:0]      exp_order;
    } row_t;

    logic    clk;
    logic    rst_n;
    logic    flush;
    logic    disp_valid;
    uop_t    disp_uop;
    wb_bus_t wb_bus [`NUM_WB];
    logic    issue_credit;
    logic    disp_credit;
    logic    issue_valid;
    uop_t    issue_uop;

    row_t    rows [$];
    int      disp_cnt;      // dispatcher side credit counter
    int      errors;
    int      checks;

    rs_alu_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .disp_valid   (disp_valid),
        .disp_uop     (disp_uop),
        .wb_bus       (wb_bus),
        .issue_credit (issue_credit),
        .disp_credit  (disp_credit),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_uop(input string name, input uop_t got, input uop_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // random payload around the fields a scenario cares about
    function automatic uop_t make_uop(input int inst, input phys_tag_t t1, input logic r1,
                                      input phys_tag_t t2, input logic r2);
        uop_t u;
        u.inst_num  = inst;
        u.pc        = $urandom;
        u.rd        = $urandom;
        u.alu_op    = $urandom;
        u.src1_sel  = $urandom;
        u.src2_sel  = $urandom;
        u.imm       = $urandom;
        u.src1.tag  = t1;
        u.src1.rdy  = r1;
        u.src2.tag  = t2;
        u.src2.rdy  = r2;
        return u;
    endfunction

    function automatic void add_uop(inout row_t r, input int cyc, input uop_t u);
        r.uops[r.n_uops]     = u;
        r.disp_cyc[r.n_uops] = cyc;
        r.n_uops++;
    endfunction

    function automatic void add_wb(inout row_t r, input int bus, input phys_tag_t tag,
                                   input int cyc);
        r.wb_idx[r.n_wb] = bus;
        r.wb_tag[r.n_wb] = tag;
        r.wb_cyc[r.n_wb] = cyc;
        r.n_wb++;
    endfunction

    function automatic void add_exp(inout row_t r, input int inst);
        r.exp_order[r.n_exp] = inst;
        r.n_exp++;
    endfunction

    // the issued op is the dispatched one with both operands marked ready
    function automatic uop_t expected_uop(input row_t r, input word_t inst);
        uop_t u;
        u = '0;
        for (int k = 0; k < r.n_uops; k++) begin
            if (r.uops[k].inst_num == inst) u = r.uops[k];
        end
        u.src1.rdy = 1'b1;
        u.src2.rdy = 1'b1;
        return u;
    endfunction

    task automatic build_table();
        row_t      r;
        phys_tag_t t1;
        phys_tag_t t2;
        r = '0;
        r.scen = 1;
        add_uop(r, 2, make_uop(10, $urandom, 1'b1, $urandom, 1'b1));
        r.first_cyc = 4;
        add_exp(r, 10);
        rows.push_back(r);
        for (int b = 0; b < `NUM_WB; b++) begin
            t1 = $urandom;
            t2 = t1 ^ phys_tag_t'(1 + $urandom % 255);  // never equal to t1
            r = '0;
            r.scen = 2;
            add_uop(r, 1, make_uop(20 + b, t1, 1'b0, t2, 1'b0));
            add_wb(r, b, t1, 4);
            add_wb(r, b, t2, 8);
            r.first_cyc = 10;
            add_exp(r, 20 + b);
            rows.push_back(r);
        end
        t1 = $urandom;
        t2 = t1 ^ 8'h3c;
        r = '0;
        r.scen = 3;
        add_uop(r, 2, make_uop(30, t1, 1'b0, t2, 1'b0));
        add_wb(r, 1, t1, 2);        // same cycle as the dispatch
        add_wb(r, 4, t2, 2);
        r.first_cyc = 4;
        add_exp(r, 30);
        rows.push_back(r);
        r = '0;
        r.scen = 4;
        // 40 leaves early so 42 reuses slot 0 while the older 41 sits in slot 1
        add_uop(r, 0, make_uop(40, $urandom, 1'b1, $urandom, 1'b1));
        for (int k = 1; k < 4; k++) begin
            add_uop(r, k, make_uop(40 + k, t1, 1'b0, $urandom, 1'b1));
        end
        for (int k = 0; k < 4; k++) begin
            add_exp(r, 40 + k);
        end
        add_wb(r, 0, t1, 5);
        r.first_cyc = 2;
        rows.push_back(r);
        r = '0;
        r.scen = 4;
        add_uop(r, 0, make_uop(50, t1, 1'b0, $urandom, 1'b1));
        for (int k = 1; k < 4; k++) begin
            add_uop(r, k, make_uop(50 + k, $urandom, 1'b1, t2, 1'b0));
        end
        add_wb(r, 0, t2, 5);
        add_wb(r, 1, t1, 6);        // oldest wakes one cycle late and still goes next
        add_exp(r, 51);
        add_exp(r, 50);
        add_exp(r, 52);
        add_exp(r, 53);
        rows.push_back(r);
        r = '0;
        r.scen = 5;
        for (int k = 0; k < 4; k++) begin
            add_uop(r, k, make_uop(60 + k, $urandom, 1'b1, $urandom, 1'b1));
            add_exp(r, 60 + k);
        end
        r.withhold = 1'b1;
        r.credit_cyc = 20;
        rows.push_back(r);
        r = '0;
        r.scen = 6;
        add_uop(r, 0, make_uop(70, t1, 1'b0, $urandom, 1'b1));
        add_uop(r, 1, make_uop(71, t2, 1'b0, $urandom, 1'b1));
        add_uop(r, 6, make_uop(72, $urandom, 1'b1, $urandom, 1'b1));
        add_uop(r, 7, make_uop(73, $urandom, 1'b1, $urandom, 1'b1));
        add_wb(r, 2, t1, 9);        // flushed entries must stay dead
        add_wb(r, 3, t2, 10);
        r.flush_cyc = 4;
        r.first_cyc = 8;
        add_exp(r, 72);
        add_exp(r, 73);
        rows.push_back(r);
    endtask

    task automatic run_row(input row_t r, input int id);
        int  cyc;
        int  next_disp;
        int  n_iss;
        int  pend;
        int  returned;
        int  quiet;
        int  gap;
        bit  flush_prev;
        cyc        = 0;
        next_disp  = 0;
        n_iss      = 0;
        pend       = 0;
        returned   = 0;
        quiet      = 0;
        gap        = 0;
        flush_prev = 1'b0;
        while (!(cyc >= 30 && next_disp == r.n_uops && n_iss == r.n_exp && pend == 0
                 && quiet >= 8)) begin
            if (cyc >= 300) begin
                $display("row %0d timed out with %0d of %0d issues seen", id, n_iss, r.n_exp);
                $display("Simulation failed");
                $finish;
            end
            @(posedge clk);
            quiet++;    // outputs below belong to cycle cyc-1
            check_count("disp_credit", disp_credit, issue_valid);
            if (issue_valid) begin
                quiet = 0;
                pend++;
                if (n_iss < r.n_exp) begin
                    check_uop("issue_uop", issue_uop, expected_uop(r, r.exp_order[n_iss]));
                    if (n_iss == 0 && r.first_cyc != 0) begin
                        check_count("first issue cycle", cyc - 1, r.first_cyc);
                    end
                end else begin
                    errors++;
                    $display("row %0d issued inst %0d that should never issue", id,
                             issue_uop.inst_num);
                end
                n_iss++;
                if (n_iss > `ISSUE_CREDITS + returned) begin
                    errors++;
                    $display("row %0d issued more ops than the alu granted credits", id);
                end
            end
            if (flush_prev) disp_cnt = `RS_DEPTH;
            else if (disp_credit) disp_cnt++;
            disp_valid   <= 1'b0;
            flush        <= 1'b0;
            issue_credit <= 1'b0;
            for (int b = 0; b < `NUM_WB; b++) begin
                wb_bus[b] <= '0;
            end
            flush_prev = 1'b0;
            if (r.flush_cyc != 0 && cyc == r.flush_cyc) begin
                flush      <= 1'b1;
                flush_prev = 1'b1;
            end else if (next_disp < r.n_uops && cyc >= r.disp_cyc[next_disp]
                         && disp_cnt > 0) begin
                disp_valid <= 1'b1;
                disp_uop   <= r.uops[next_disp];
                disp_cnt--;
                next_disp++;
            end
            for (int e = 0; e < r.n_wb; e++) begin
                if (r.wb_cyc[e] == cyc) begin
                    wb_bus[r.wb_idx[e]] <= '{valid: 1'b1, tag: r.wb_tag[e]};
                end
            end
            if (r.withhold && cyc == r.credit_cyc) begin
                check_count("issues while credits withheld", n_iss, `ISSUE_CREDITS);
            end
            if (pend > 0 && (!r.withhold || (cyc >= r.credit_cyc && gap == 0))) begin
                issue_credit <= 1'b1;
                pend--;
                returned++;
                gap = r.withhold ? 3 : 0;
            end else if (gap > 0) begin
                gap--;
            end
            cyc++;
        end
        check_count("issue count", n_iss, r.n_exp);
        check_count("dispatch credits", disp_cnt, `RS_DEPTH);
    endtask

    // waiting ops fill the station until the dispatcher runs dry and then get flushed
    task automatic fill_and_flush();
        int sent;
        int cyc;
        sent = 0;
        for (cyc = 0; cyc < 20; cyc++) begin
            @(posedge clk);
            if (issue_valid) begin
                errors++;
                $display("an op left the station although no source was ready");
            end
            if (disp_credit) disp_cnt++;
            disp_valid <= 1'b0;
            if (disp_cnt > 0) begin
                disp_valid <= 1'b1;
                disp_uop   <= make_uop(90 + sent, 8'hf0, 1'b0, 8'hf1, 1'b0);
                disp_cnt--;
                sent++;
            end
        end
        check_count("entries filled", sent, `RS_DEPTH);
        check_count("dispatch credits when full", disp_cnt, 0);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush    <= 1'b0;
        disp_cnt = `RS_DEPTH;
        // the tags the flushed ops were waiting on show up right after the flush
        wb_bus[0] <= '{valid: 1'b1, tag: 8'hf0};
        wb_bus[3] <= '{valid: 1'b1, tag: 8'hf1};
        for (cyc = 0; cyc < 15; cyc++) begin
            @(posedge clk);
            check_count("issue_valid after flush", issue_valid, 0);
            check_count("disp_credit after flush", disp_credit, 0);
            wb_bus[0] <= '0;
            wb_bus[3] <= '0;
        end
    endtask

    initial begin
        int seed_val;
        int errs_before;
        seed_val     = $urandom(32'h4a9d_0cad);
        errors       = 0;
        checks       = 0;
        disp_cnt     = `RS_DEPTH;
        rst_n        <= 1'b0;
        flush        <= 1'b0;
        disp_valid   <= 1'b0;
        disp_uop     <= '0;
        issue_credit <= 1'b0;
        for (int b = 0; b < `NUM_WB; b++) begin
            wb_bus[b] <= '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_count("issue_valid after reset", issue_valid, 0);
        check_count("disp_credit after reset", disp_credit, 0);
        build_table();
        foreach (rows[i]) begin
            errs_before = errors;
            run_row(rows[i], i);
            $display("row %0d scenario %0d: %s", i, rows[i].scen,
                     errors == errs_before ? "ok" : "errors");
        end
        errs_before = errors;
        fill_and_flush();
        run_row(rows[0], rows.size());
        $display("fill, stall and flush: %s", errors == errs_before ? "ok" : "errors");
        $display("rows %0d, checks %0d, errors %0d", rows.size() + 1, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rtl/rs_alu_top.sv ====
`timescale 1ns/1ps
`include "rs_alu_macros.svh"

module rs_alu_top
    import rs_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     disp_valid,
    input  uop_t     disp_uop,
    input  wb_bus_t  wb_bus [`NUM_WB],
    input  logic     issue_credit,
    output logic     disp_credit,
    output logic     issue_valid,
    output uop_t     issue_uop
);

    rs_entry_t            entries [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] wake1;
    logic [`RS_DEPTH-1:0] wake2;
    logic                 disp_wake1;
    logic                 disp_wake2;
    logic [`RS_DEPTH-1:0] ready_vec;
    logic [`RS_DEPTH-1:0] alloc_onehot;
    logic [`RS_DEPTH-1:0] grant_onehot;
    logic [`RS_DEPTH-1:0] release_onehot;
    logic                 issue_en;

    rs_wakeup u_wakeup (
        .entries    (entries),
        .disp_uop   (disp_uop),
        .wb_bus     (wb_bus),
        .wake1      (wake1),
        .wake2      (wake2),
        .disp_wake1 (disp_wake1),
        .disp_wake2 (disp_wake2)
    );

    rs_entry_array u_entries (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .disp_valid     (disp_valid),
        .disp_uop       (disp_uop),
        .disp_wake1     (disp_wake1),
        .disp_wake2     (disp_wake2),
        .wake1          (wake1),
        .wake2          (wake2),
        .release_onehot (release_onehot),
        .entries        (entries),
        .busy_vec       (),
        .ready_vec      (ready_vec),
        .alloc_onehot   (alloc_onehot)
    );

    rs_age_matrix u_age (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .alloc_onehot (alloc_onehot),
        .ready_vec    (ready_vec),
        .issue_en     (issue_en),
        .grant_onehot (grant_onehot)
    );

    rs_issue_stage u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .entries        (entries),
        .grant_onehot   (grant_onehot),
        .issue_credit   (issue_credit),
        .issue_en       (issue_en),
        .release_onehot (release_onehot),
        .disp_credit    (disp_credit),
        .issue_valid    (issue_valid),
        .issue_uop      (issue_uop)
    );

endmodule

// ==== rtl/rs_issue_stage.sv ====
`timescale 1ns/1ps
`include "rs_alu_macros.svh"

module rs_issue_stage
    import rs_alu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  rs_entry_t             entries [`RS_DEPTH],
    input  logic [`RS_DEPTH-1:0]  grant_onehot,
    input  logic                  issue_credit,
    output logic                  issue_en,
    output logic [`RS_DEPTH-1:0]  release_onehot,
    output logic                  disp_credit,
    output logic                  issue_valid,
    output uop_t                  issue_uop
);

    logic [`ISSUE_CNT_W-1:0] credit_q;
    logic                    fire;
    uop_t                    pick;

    // nothing leaves while flushing
    assign issue_en       = (credit_q != '0) && !flush;
    assign fire           = |grant_onehot;
    assign release_onehot = grant_onehot;

    // grant is one-hot so an or-mux is enough
    always_comb begin
        pick = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (grant_onehot[i]) begin
                pick = pick | entries[i].uop;
            end
        end
        pick.src1.rdy = 1'b1;
        pick.src2.rdy = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_q    <= `ISSUE_CREDITS;
            issue_valid <= 1'b0;
            disp_credit <= 1'b0;
        end else begin
            issue_valid <= fire;
            disp_credit <= fire;    // slot freed by this issue
            case ({issue_credit, fire})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue_uop <= pick;
        end
    end

endmodule

// ==== rtl/rs_age_matrix.sv ====
`timescale 1ns/1ps
`include "rs_alu_macros.svh"

module rs_age_matrix
    import rs_alu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic [`RS_DEPTH-1:0]  alloc_onehot,
    input  logic [`RS_DEPTH-1:0]  ready_vec,
    input  logic                  issue_en,
    output logic [`RS_DEPTH-1:0]  grant_onehot
);

    // older_q[r][c]: entry r is older than entry c
    logic [`RS_DEPTH-1:0] older_q [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] older_col;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int r = 0; r < `RS_DEPTH; r++) begin
                older_q[r] <= '0;
            end
        end else begin
            for (int r = 0; r < `RS_DEPTH; r++) begin
                for (int c = 0; c < `RS_DEPTH; c++) begin
                    if (alloc_onehot[c] && r != c) begin
                        older_q[r][c] <= 1'b1;  // everyone precedes the newcomer
                    end else if (alloc_onehot[r]) begin
                        older_q[r][c] <= 1'b0;
                    end
                end
            end
        end
    end

    // oldest ready entry has no older ready entry in its column
    always_comb begin
        grant_onehot = '0;
        older_col    = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            for (int j = 0; j < `RS_DEPTH; j++) begin
                older_col[j] = older_q[j][i];
            end
            grant_onehot[i] = issue_en && ready_vec[i] && !(|(older_col & ready_vec));
        end
    end

endmodule

// ==== rtl/rs_entry_array.sv ====
`timescale 1ns/1ps
`include "rs_alu_macros.svh"

module rs_entry_array
    import rs_alu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  uop_t                  disp_uop,
    input  logic                  disp_wake1,
    input  logic                  disp_wake2,
    input  logic [`RS_DEPTH-1:0]  wake1,
    input  logic [`RS_DEPTH-1:0]  wake2,
    input  logic [`RS_DEPTH-1:0]  release_onehot,
    output rs_entry_t             entries [`RS_DEPTH],
    output logic [`RS_DEPTH-1:0]  busy_vec,
    output logic [`RS_DEPTH-1:0]  ready_vec,
    output logic [`RS_DEPTH-1:0]  alloc_onehot
);

    logic [`RS_DEPTH-1:0] busy_q;
    uop_t                 uop_q [`RS_DEPTH];
    logic [`RS_IDX_W-1:0] free_idx;
    logic                 free_any;
    uop_t                 wr_uop;

    // lowest free slot, scanned downwards so index 0 wins
    always_comb begin
        free_idx = '0;
        free_any = 1'b0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_idx = i[`RS_IDX_W-1:0];
                free_any = 1'b1;
            end
        end
    end

    always_comb begin
        alloc_onehot = '0;
        if (disp_valid && free_any && !flush) begin
            alloc_onehot[free_idx] = 1'b1;
        end
    end

    // source counts as ready if already in the rf or broadcast right now
    always_comb begin
        wr_uop          = disp_uop;
        wr_uop.src1.rdy = disp_uop.src1.rdy | disp_wake1;
        wr_uop.src2.rdy = disp_uop.src2.rdy | disp_wake2;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (alloc_onehot[i]) begin
                uop_q[i] <= wr_uop;
            end else begin
                if (wake1[i]) uop_q[i].src1.rdy <= 1'b1;
                if (wake2[i]) uop_q[i].src2.rdy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else if (flush) begin
            busy_q <= '0;       // drop everything held
        end else begin
            busy_q <= (busy_q & ~release_onehot) | alloc_onehot;
        end
    end

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entries[i].busy = busy_q[i];
            entries[i].uop  = uop_q[i];
            ready_vec[i]    = busy_q[i] & uop_q[i].src1.rdy & uop_q[i].src2.rdy;
        end
    end

    assign busy_vec = busy_q;

endmodule

// ==== rtl/rs_wakeup.sv ====
`timescale 1ns/1ps
`include "rs_alu_macros.svh"

module rs_wakeup
    import rs_alu_pkg::*;
(
    input  rs_entry_t             entries [`RS_DEPTH],
    input  uop_t                  disp_uop,
    input  wb_bus_t               wb_bus [`NUM_WB],
    output logic [`RS_DEPTH-1:0]  wake1,
    output logic [`RS_DEPTH-1:0]  wake2,
    output logic                  disp_wake1,
    output logic                  disp_wake2
);

    // any valid broadcast carrying this tag
    function automatic logic tag_hit(input phys_tag_t tag, input wb_bus_t bus [`NUM_WB]);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < `NUM_WB; b++) begin
            if (bus[b].valid && bus[b].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            wake1[i] = entries[i].busy && tag_hit(entries[i].uop.src1.tag, wb_bus);
            wake2[i] = entries[i].busy && tag_hit(entries[i].uop.src2.tag, wb_bus);
        end
    end

    // bypass for a consumer arriving in the broadcast cycle
    assign disp_wake1 = tag_hit(disp_uop.src1.tag, wb_bus);
    assign disp_wake2 = tag_hit(disp_uop.src2.tag, wb_bus);

endmodule

// ==== rtl/rs_alu_pkg.sv ====
`include "rs_alu_macros.svh"

package rs_alu_pkg;

    typedef logic [`TAG_W-1:0]  phys_tag_t;
    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`OPC_W-1:0]  alu_op_t;

    // one result broadcast
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } wb_bus_t;

    typedef struct packed {
        phys_tag_t tag;
        logic      rdy;     // value is in the register file
    } src_t;

    // dispatch word and issue payload
    typedef struct packed {
        word_t     inst_num;
        word_t     pc;
        phys_tag_t rd;
        alu_op_t   alu_op;
        logic      src1_sel;    // operand 1 from pc
        logic      src2_sel;    // operand 2 from imm
        word_t     imm;
        src_t      src1;
        src_t      src2;
    } uop_t;

    typedef struct packed {
        logic busy;
        uop_t uop;
    } rs_entry_t;

endpackage

// ==== include/rs_alu_macros.svh ====
`ifndef RS_ALU_MACROS_SVH
`define RS_ALU_MACROS_SVH

// station geometry
`define RS_DEPTH        8
`define RS_IDX_W        3

// datapath fields
`define TAG_W           8
`define WORD_W          32
`define OPC_W           4

// producers that broadcast results (alu, mul, div, load, branch, p-unit)
`define NUM_WB          6

// credit pools
`define ISSUE_CREDITS   2
`define ISSUE_CNT_W     2   // holds 0..ISSUE_CREDITS
`define DISP_CNT_W      4   // holds 0..RS_DEPTH on the dispatcher side

`endif
